//--- tb.f
+incdir+include
hw/br_pkg.sv
hw/branch_rs.sv
hw/br_operand_read.sv
hw/branch_resolve.sv
hw/branch_cluster.sv
tb/tb_branch_cluster.sv

//--- Makefile
TOP = tb_branch_cluster

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing -f tb.f --top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then \
		echo "simulation reported a failure"; \
		exit 1; \
	fi
	@if ! grep -q "Simulation finished: PASS" sim.log; then \
		echo "simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- tb/tb_branch_cluster.sv
`timescale 1ns/100ps
`include "br_cfg.svh"

module tb_branch_cluster;

    typedef struct packed {
        logic                 dv;
        br_pkg::br_dispatch_t d;
        logic [1:0]           bad;   // 1 flips direction, 2 skews target
        logic [`BR_TAG_W-1:0] bc;    // broadcast tag, 0 for none
        logic [1:0]           exp;   // bit 1 rs_full, bit 0 result due
    } step_t;

    logic                                clk;
    logic                                reset;
    logic                                dispatch_valid;
    br_pkg::br_dispatch_t                dispatch;
    br_pkg::br_wb_t [`BR_WB_PORTS-1:0]   wb;
    logic                                rs_full;
    br_pkg::br_result_t                  result;
    logic                                flush;

    step_t               table_q [$];
    br_pkg::br_result_t  exp_q [$];
    logic [`BR_XLEN-1:0] val [1 << `BR_TAG_W];  // values the testbench broadcasts
    int                  cycle_cnt = 0;
    int                  limit = 100000;

    branch_cluster UUT (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .wb             (wb),
        .rs_full        (rs_full),
        .result         (result),
        .flush          (flush)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > limit) begin
            $display("timeout after %0d cycles, the test did not complete", cycle_cnt);
            stop_run();
        end
    end

    task automatic stop_run();
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    // expected outcome straight from the RV32 branch rules
    function automatic br_pkg::br_result_t branch_ref(input br_pkg::br_dispatch_t d,
                                                      input logic [`BR_XLEN-1:0] a,
                                                      input logic [`BR_XLEN-1:0] b);
        br_pkg::br_result_t   r;
        logic [`BR_XLEN-1:0]  tgt;
        logic                 tk;
        tk  = 1'b1;
        tgt = d.pc + d.imm;
        if (d.op == br_pkg::op_jalr) begin
            tgt = (a + d.imm) & ~32'd1;
        end
        if (d.op == br_pkg::op_branch) begin
            case (d.cond)
                br_pkg::cond_beq:  tk = a == b;
                br_pkg::cond_bne:  tk = a != b;
                br_pkg::cond_blt:  tk = $signed(a) < $signed(b);
                br_pkg::cond_bge:  tk = $signed(a) >= $signed(b);
                br_pkg::cond_bltu: tk = a < b;
                default:           tk = a >= b;  // bgeu
            endcase
        end
        r.valid       = 1'b1;
        r.seq         = d.seq;
        r.taken       = tk;
        r.mispredict  = (tk != d.pred_taken) || (tk && tgt != d.pred_target);
        r.redirect_pc = tk ? tgt : d.pc + 32'd4;
        r.rd          = d.rd;
        r.rd_en       = d.rd_en;
        r.link        = d.pc + 32'd4;
        return r;
    endfunction

    task automatic compare_result(input br_pkg::br_result_t got, input br_pkg::br_result_t exp);
        if ((exp.valid && got !== exp) || (!exp.valid && got.valid !== 1'b0)) begin
            $display("MISMATCH at %0t: result got %h expected %h", $time, got, exp);
            stop_run();
        end
    endtask

    task automatic compare_flush(input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: flush got %b expected %b", $time, got, exp);
            stop_run();
        end
    endtask

    task automatic compare_full(input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: rs_full got %b expected %b", $time, got, exp);
            stop_run();
        end
    endtask

    task automatic add_step(input logic dv, input br_pkg::br_op_e op,
                            input br_pkg::br_cond_e cond, input logic [31:0] pc,
                            input logic [31:0] imm, input int rd, input int rs1, input int rs2,
                            input logic [1:0] rdy, input int bad, input int bc,
                            input logic [1:0] exp);
        step_t st;
        st             = '0;
        st.dv          = dv;
        st.d.op        = op;
        st.d.cond      = cond;
        st.d.pc        = pc;
        st.d.imm       = imm;
        st.d.rd        = `BR_TAG_W'(rd);
        st.d.rd_en     = rd != 0;
        st.d.rs1       = `BR_TAG_W'(rs1);
        st.d.rs2       = `BR_TAG_W'(rs2);
        st.d.rs1_ready = rdy[1];
        st.d.rs2_ready = rdy[0];
        st.bad         = 2'(bad);
        st.bc          = `BR_TAG_W'(bc);
        st.exp         = exp;
        table_q.push_back(st);
    endtask

    task automatic branch(input br_pkg::br_cond_e cond, input logic [31:0] pc,
                          input logic [31:0] imm, input int rs1, input int rs2,
                          input logic [1:0] rdy, input int bad, input logic [1:0] exp);
        add_step(1'b1, br_pkg::op_branch, cond, pc, imm, 0, rs1, rs2, rdy, bad, 0, exp);
    endtask

    task automatic jump(input br_pkg::br_op_e op, input logic [31:0] pc, input logic [31:0] imm,
                        input int rd, input int rs1, input int bad, input logic [1:0] exp);
        add_step(1'b1, op, br_pkg::cond_beq, pc, imm, rd, rs1, 0, 2'b11, bad, 0, exp);
    endtask

    task automatic idle(input int n, input logic [1:0] exp);
        for (int i = 0; i < n; i++) begin
            add_step(1'b0, br_pkg::op_branch, br_pkg::cond_beq, '0, '0, 0, 0, 0, 2'b00, 0, 0, exp);
        end
    endtask

    task automatic bcast(input int tag, input logic [1:0] exp);
        add_step(1'b0, br_pkg::op_branch, br_pkg::cond_beq, '0, '0, 0, 0, 0, 2'b00, 0, tag, exp);
    endtask

    // tags 1..6 hold extremes, 70..73 come late, 100/101 are link targets
    task automatic build_table();
        branch(br_pkg::cond_beq,  'h100, 'h40, 1, 5, 2'b11, 0, 2'd0);
        branch(br_pkg::cond_beq,  'h104, 'h40, 1, 2, 2'b11, 0, 2'd0);
        branch(br_pkg::cond_bne,  'h108, 'hffffffe0, 1, 2, 2'b11, 0, 2'd0);
        branch(br_pkg::cond_bne,  'h10c, 'h40, 1, 5, 2'b11, 0, 2'd0);
        branch(br_pkg::cond_blt,  'h110, 'h20, 1, 2, 2'b11, 0, 2'd1);
        branch(br_pkg::cond_blt,  'h114, 'h20, 2, 1, 2'b11, 0, 2'd1);
        branch(br_pkg::cond_bge,  'h118, 'hfffffff0, 2, 1, 2'b11, 0, 2'd1);
        branch(br_pkg::cond_bge,  'h11c, 'h20, 1, 2, 2'b11, 0, 2'd1);
        branch(br_pkg::cond_bltu, 'h120, 'h80, 4, 3, 2'b11, 0, 2'd1);
        branch(br_pkg::cond_bltu, 'h124, 'h80, 1, 2, 2'b11, 0, 2'd1);
        branch(br_pkg::cond_bgeu, 'h128, 'h10, 1, 2, 2'b11, 0, 2'd1);
        branch(br_pkg::cond_bgeu, 'h12c, 'h10, 6, 4, 2'b11, 0, 2'd1);
        idle(4, 2'd1);
        idle(1, 2'd0);
        // jal link wakes the dependent bne, jalr queued behind it
        jump(br_pkg::op_jal, 'h200, 'h80, 100, 0, 0, 2'd0);
        branch(br_pkg::cond_bne, 'h280, 'h24, 100, 6, 2'b01, 0, 2'd0);
        jump(br_pkg::op_jalr, 'h284, 'h3, 101, 1, 0, 2'd0);  // odd sum
        idle(1, 2'd0);
        idle(1, 2'd1);
        idle(3, 2'd0);
        idle(2, 2'd1);
        // head waits on two late tags, younger ready branch stays behind
        branch(br_pkg::cond_blt, 'h400, 'h100, 70, 71, 2'b00, 0, 2'd0);
        branch(br_pkg::cond_beq, 'h404, 'h100, 1, 5, 2'b11, 0, 2'd0);
        idle(2, 2'd0);
        bcast(70, 2'd0);
        bcast(71, 2'd0);
        idle(3, 2'd0);
        idle(2, 2'd1);
        // wrong direction flushes exec, issue and the waiting entry
        branch(br_pkg::cond_beq, 'h500, 'h40, 1, 2, 2'b11, 1, 2'd0);
        branch(br_pkg::cond_bne, 'h504, 'h40, 1, 2, 2'b11, 0, 2'd0);
        jump(br_pkg::op_jal, 'h508, 'h100, 0, 0, 0, 2'd0);
        branch(br_pkg::cond_bne, 'h50c, 'h40, 72, 0, 2'b01, 0, 2'd0);
        branch(br_pkg::cond_beq, 'h510, 'h40, 1, 5, 2'b11, 0, 2'd1);  // lands in flush cycle
        bcast(72, 2'd0);
        branch(br_pkg::cond_bge, 'h600, 'h40, 2, 1, 2'b11, 0, 2'd0);
        idle(3, 2'd0);
        idle(1, 2'd1);
        jump(br_pkg::op_jal, 'h700, 'h60, 0, 0, 2, 2'd0);  // wrong target
        idle(3, 2'd0);
        idle(1, 2'd1);
        idle(1, 2'd0);
        // fill the station on a tag that is not yet produced
        for (int k = 0; k < `BR_RS_DEPTH; k++) begin
            branch(br_pkg::cond_beq, 32'h800 + 32'(4 * k), 'h40, 73, 0, 2'b01, 0, 2'd0);
        end
        bcast(73, 2'd2);
        idle(1, 2'd2);
        idle(2, 2'd0);
        idle(`BR_RS_DEPTH, 2'd1);
        idle(2, 2'd0);
    endtask

    initial begin
        step_t                st;
        br_pkg::br_dispatch_t d;
        br_pkg::br_result_t   e;
        logic [`BR_XLEN-1:0]  a;
        logic [`BR_XLEN-1:0]  b;
        logic [7:0]           seq;
        logic                 flushing;
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        wb             = '0;
        seq            = '0;
        void'($urandom(32'hfd32e4f3));
        for (int i = 0; i < (1 << `BR_TAG_W); i++) begin
            val[i] = $urandom();
        end
        val[0] = '0;
        val[1] = 32'h8000_0000;
        val[2] = 32'h7fff_ffff;
        val[3] = 32'hffff_ffff;
        val[4] = 32'h0000_0001;
        val[5] = 32'h8000_0000;
        val[6] = 32'h0000_0000;
        build_table();
        limit = table_q.size() * 8 + 100;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // early tags go into the register copy before the table starts
        for (int t = 1; t < 64; t += `BR_WB_PORTS) begin
            for (int p = 0; p < `BR_WB_PORTS; p++) begin
                wb[p].valid = 1'b1;
                wb[p].tag   = `BR_TAG_W'(t + p);
                wb[p].data  = val[t + p];
            end
            @(negedge clk);
        end
        wb = '0;
        foreach (table_q[i]) begin
            st = table_q[i];
            e  = '0;
            if (st.exp[0]) begin
                if (exp_q.size() == 0) begin
                    $display("step %0d expects a result but none is outstanding", i);
                    stop_run();
                end
                e = exp_q.pop_front();
            end
            compare_result(result, e);
            compare_flush(flush, e.valid && e.mispredict);
            compare_full(rs_full, st.exp[1]);
            flushing = e.valid && e.mispredict;
            if (flushing) begin
                exp_q.delete();
            end

            d     = st.d;
            d.seq = seq;
            a     = val[d.rs1];
            b     = val[d.rs2];
            e     = branch_ref(d, a, b);
            d.pred_taken  = e.taken ^ (st.bad == 2'd1);
            d.pred_target = e.redirect_pc + ((st.bad == 2'd2) ? 32'd8 : 32'd0);
            e = branch_ref(d, a, b);
            if (st.dv) begin
                if (d.op != br_pkg::op_branch && d.rd_en) begin
                    val[d.rd] = d.pc + 32'd4;  // link value seen by dependents
                end
                if (!flushing) begin
                    exp_q.push_back(e);
                end
                seq++;
            end
            dispatch_valid = st.dv;
            dispatch       = d;
            wb             = '0;
            if (st.bc != '0) begin
                wb[0].valid = 1'b1;
                wb[0].tag   = st.bc;
                wb[0].data  = val[st.bc];
            end
            @(negedge clk);
        end
        if (exp_q.size() != 0) begin
            $display("%0d expected results never came out", exp_q.size());
            stop_run();
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

//--- hw/branch_cluster.sv
`timescale 1ns/100ps
`include "br_cfg.svh"

module branch_cluster (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                dispatch_valid,
    input  br_pkg::br_dispatch_t                dispatch,
    input  br_pkg::br_wb_t [`BR_WB_PORTS-1:0]   wb,
    output logic                                rs_full,
    output br_pkg::br_result_t                  result,
    output logic                                flush
);

    localparam int WB_N = `BR_WB_PORTS + 1;

    br_pkg::br_wb_t             link_wb;
    br_pkg::br_wb_t [WB_N-1:0]  wb_all;
    br_pkg::br_issue_t          issue;
    br_pkg::br_exec_t           exec;

    // jump link value wakes up dependent branches
    assign link_wb.valid = result.valid && result.rd_en;
    assign link_wb.tag   = result.rd;
    assign link_wb.data  = result.link;

    assign wb_all = {link_wb, wb};  // link broadcast on the top port

    assign flush = result.valid && result.mispredict;

    branch_rs #(.WB_N(WB_N)) u_rs (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .wb             (wb_all),
        .flush          (flush),
        .rs_full        (rs_full),
        .issue          (issue)
    );

    br_operand_read #(.WB_N(WB_N)) u_read (
        .clk   (clk),
        .reset (reset),
        .wb    (wb_all),
        .issue (issue),
        .flush (flush),
        .exec  (exec)
    );

    branch_resolve u_resolve (
        .clk    (clk),
        .reset  (reset),
        .exec   (exec),
        .result (result)
    );

endmodule

//--- hw/branch_resolve.sv
`timescale 1ns/100ps
`include "br_cfg.svh"

module branch_resolve (
    input  logic                clk,
    input  logic                reset,
    input  br_pkg::br_exec_t    exec,
    output br_pkg::br_result_t  result
);

    logic                cond_true;
    logic                taken;
    logic                mispredict;
    logic                kill;
    logic [`BR_XLEN-1:0]  jalr_sum;
    logic [`BR_XLEN-1:0]  target;
    logic [`BR_XLEN-1:0]  link;
    logic [`BR_XLEN-1:0]  redirect_pc;

    always_comb begin
        case (exec.inst.cond)
            br_pkg::cond_beq:  cond_true = exec.src1 == exec.src2;
            br_pkg::cond_bne:  cond_true = exec.src1 != exec.src2;
            br_pkg::cond_blt:  cond_true = $signed(exec.src1) < $signed(exec.src2);
            br_pkg::cond_bge:  cond_true = $signed(exec.src1) >= $signed(exec.src2);
            br_pkg::cond_bltu: cond_true = exec.src1 < exec.src2;
            br_pkg::cond_bgeu: cond_true = exec.src1 >= exec.src2;
            default:           cond_true = 1'b0;  // unused funct3
        endcase
    end

    assign jalr_sum = exec.src1 + exec.inst.imm;
    assign link     = exec.inst.pc + `BR_XLEN'(4);

    always_comb begin
        case (exec.inst.op)
            br_pkg::op_branch: begin
                taken  = cond_true;
                target = exec.inst.pc + exec.inst.imm;
            end
            br_pkg::op_jalr: begin
                taken  = 1'b1;
                target = {jalr_sum[`BR_XLEN-1:1], 1'b0};  // lsb cleared
            end
            default: begin  // jal
                taken  = 1'b1;
                target = exec.inst.pc + exec.inst.imm;
            end
        endcase
    end

    assign redirect_pc = taken ? target : link;

    // direction wrong, or taken to a wrong place
    assign mispredict = (taken != exec.inst.pred_taken)
                     || (taken && target != exec.inst.pred_target);

    // younger instruction behind a mispredicted one never resolves
    assign kill = result.valid && result.mispredict;

    always_ff @(posedge clk) begin
        if (reset) begin
            result.valid <= 1'b0;
        end else begin
            result.valid       <= exec.inst.valid && !kill;
            result.seq         <= exec.inst.seq;
            result.taken       <= taken;
            result.mispredict  <= mispredict;
            result.redirect_pc <= redirect_pc;
            result.rd          <= exec.inst.rd;
            result.rd_en       <= exec.inst.rd_en;
            result.link        <= link;
        end
    end

endmodule

//--- hw/br_operand_read.sv
`timescale 1ns/100ps
`include "br_cfg.svh"

module br_operand_read #(
    parameter int WB_N = `BR_WB_PORTS + 1
) (
    input  logic                        clk,
    input  logic                        reset,
    input  br_pkg::br_wb_t [WB_N-1:0]   wb,
    input  br_pkg::br_issue_t           issue,
    input  logic                        flush,
    output br_pkg::br_exec_t            exec
);

    localparam int N_REGS = 1 << `BR_TAG_W;

    // local copy of the physical register file
    logic [`BR_XLEN-1:0] prf_q [N_REGS];
    logic [`BR_XLEN-1:0] src1;
    logic [`BR_XLEN-1:0] src2;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < N_REGS; i++) begin
                prf_q[i] <= '0;
            end
        end else begin
            for (int p = 0; p < WB_N; p++) begin
                if (wb[p].valid && wb[p].tag != '0) begin  // x0 never written
                    prf_q[wb[p].tag] <= wb[p].data;
                end
            end
        end
    end

    // same-cycle broadcast wins over the stored word
    always_comb begin
        src1 = prf_q[issue.rs1];
        src2 = prf_q[issue.rs2];
        for (int p = 0; p < WB_N; p++) begin
            if (wb[p].valid && wb[p].tag == issue.rs1) begin
                src1 = wb[p].data;
            end
            if (wb[p].valid && wb[p].tag == issue.rs2) begin
                src2 = wb[p].data;
            end
        end
        if (issue.rs1 == '0) begin
            src1 = '0;
        end
        if (issue.rs2 == '0) begin
            src2 = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            exec.inst.valid <= 1'b0;
        end else begin
            exec.inst <= issue;
            exec.src1 <= src1;
            exec.src2 <= src2;
        end
    end

endmodule

//--- hw/branch_rs.sv
`timescale 1ns/100ps
`include "br_cfg.svh"

module branch_rs #(
    parameter int WB_N = `BR_WB_PORTS + 1
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        dispatch_valid,
    input  br_pkg::br_dispatch_t        dispatch,
    input  br_pkg::br_wb_t [WB_N-1:0]   wb,
    input  logic                        flush,
    output logic                        rs_full,
    output br_pkg::br_issue_t           issue
);

    localparam int DEPTH = `BR_RS_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    br_pkg::br_issue_t  entry_q [DEPTH];  // valid field marks an occupied slot
    logic [DEPTH-1:0]   rdy1_q;
    logic [DEPTH-1:0]   rdy2_q;
    logic [PTR_W-1:0]   head_q;
    logic [PTR_W-1:0]   tail_q;
    logic [PTR_W:0]     count_q;

    br_pkg::br_issue_t  disp_entry;
    logic               disp_rdy1;
    logic               disp_rdy2;
    logic               head_ready;
    logic               do_push;
    logic               do_issue;

    // any valid broadcast carrying this tag
    function automatic logic wb_hit(input logic [`BR_TAG_W-1:0] tag,
                                    input br_pkg::br_wb_t [WB_N-1:0] bus);
        logic hit;
        hit = 1'b0;
        for (int p = 0; p < WB_N; p++) begin
            if (bus[p].valid && bus[p].tag == tag) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    always_comb begin
        disp_entry.valid       = 1'b1;
        disp_entry.op          = dispatch.op;
        disp_entry.cond        = dispatch.cond;
        disp_entry.pc          = dispatch.pc;
        disp_entry.imm         = dispatch.imm;
        disp_entry.rd          = dispatch.rd;
        disp_entry.rd_en       = dispatch.rd_en;
        disp_entry.rs1         = dispatch.rs1;
        disp_entry.rs2         = dispatch.rs2;
        disp_entry.pred_taken  = dispatch.pred_taken;
        disp_entry.pred_target = dispatch.pred_target;
        disp_entry.seq         = dispatch.seq;
    end

    // tag 0 is x0, always ready
    assign disp_rdy1 = dispatch.rs1_ready || dispatch.rs1 == '0 || wb_hit(dispatch.rs1, wb);
    assign disp_rdy2 = dispatch.rs2_ready || dispatch.rs2 == '0 || wb_hit(dispatch.rs2, wb);

    assign rs_full    = count_q == (PTR_W + 1)'(DEPTH);
    assign head_ready = entry_q[head_q].valid && rdy1_q[head_q] && rdy2_q[head_q];
    assign do_push    = dispatch_valid && !rs_full && !flush;  // lost when full
    assign do_issue   = head_ready && !flush;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            for (int i = 0; i < DEPTH; i++) begin
                entry_q[i].valid <= 1'b0;
                rdy1_q[i]        <= 1'b0;
                rdy2_q[i]        <= 1'b0;
            end
            head_q      <= '0;
            tail_q      <= '0;
            count_q     <= '0;
            issue.valid <= 1'b0;
        end else begin
            // wakeup of waiting entries
            for (int i = 0; i < DEPTH; i++) begin
                if (wb_hit(entry_q[i].rs1, wb)) begin
                    rdy1_q[i] <= 1'b1;
                end
                if (wb_hit(entry_q[i].rs2, wb)) begin
                    rdy2_q[i] <= 1'b1;
                end
            end

            if (do_push) begin
                entry_q[tail_q] <= disp_entry;
                rdy1_q[tail_q]  <= disp_rdy1;  // overrides the wakeup above
                rdy2_q[tail_q]  <= disp_rdy2;
                tail_q          <= tail_q + 1'b1;
            end

            // strictly in order, a stalled head blocks the rest
            if (do_issue) begin
                issue                  <= entry_q[head_q];
                entry_q[head_q].valid  <= 1'b0;
                head_q                 <= head_q + 1'b1;
            end else begin
                issue.valid <= 1'b0;
            end

            case ({do_push, do_issue})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

//--- hw/br_pkg.sv
`include "br_cfg.svh"

package br_pkg;

    typedef enum logic [1:0] {
        op_branch = 2'd0,
        op_jal    = 2'd1,
        op_jalr   = 2'd2
    } br_op_e;

    // funct3 encodings of the conditional branches
    typedef enum logic [2:0] {
        cond_beq  = 3'b000,
        cond_bne  = 3'b001,
        cond_blt  = 3'b100,
        cond_bge  = 3'b101,
        cond_bltu = 3'b110,
        cond_bgeu = 3'b111
    } br_cond_e;

    typedef struct packed {
        br_op_e              op;
        br_cond_e            cond;
        logic [`BR_XLEN-1:0]  pc;
        logic [`BR_XLEN-1:0]  imm;
        logic [`BR_TAG_W-1:0] rd;
        logic                rd_en;
        logic [`BR_TAG_W-1:0] rs1;
        logic [`BR_TAG_W-1:0] rs2;
        logic                rs1_ready;  // value already in the register file
        logic                rs2_ready;
        logic                pred_taken;
        logic [`BR_XLEN-1:0]  pred_target;
        logic [7:0]          seq;
    } br_dispatch_t;

    typedef struct packed {
        logic                valid;
        logic [`BR_TAG_W-1:0] tag;
        logic [`BR_XLEN-1:0]  data;
    } br_wb_t;

    typedef struct packed {
        logic                valid;
        br_op_e              op;
        br_cond_e            cond;
        logic [`BR_XLEN-1:0]  pc;
        logic [`BR_XLEN-1:0]  imm;
        logic [`BR_TAG_W-1:0] rd;
        logic                rd_en;
        logic [`BR_TAG_W-1:0] rs1;
        logic [`BR_TAG_W-1:0] rs2;
        logic                pred_taken;
        logic [`BR_XLEN-1:0]  pred_target;
        logic [7:0]          seq;
    } br_issue_t;

    typedef struct packed {
        br_issue_t           inst;
        logic [`BR_XLEN-1:0]  src1;
        logic [`BR_XLEN-1:0]  src2;
    } br_exec_t;

    typedef struct packed {
        logic                valid;
        logic [7:0]          seq;
        logic                taken;
        logic                mispredict;
        logic [`BR_XLEN-1:0]  redirect_pc;
        logic [`BR_TAG_W-1:0] rd;
        logic                rd_en;
        logic [`BR_XLEN-1:0]  link;  // pc + 4
    } br_result_t;

endpackage

//--- include/br_cfg.svh
`ifndef BR_CFG_SVH
`define BR_CFG_SVH

// station entries, must be a power of two
`define BR_RS_DEPTH 16

// physical register tag width, 128 physical registers
`define BR_TAG_W 7

`define BR_XLEN 32

// external result broadcast ports, the link broadcast comes on top
`define BR_WB_PORTS 4

`endif
